// ==== gain_cfg.svh ====
`ifndef GAIN_CFG_SVH
`define GAIN_CFG_SVH

//////////////////////////////////////////////////
// Scratch memory map
//////////////////////////////////////////////////
`define GP_ADDR_W         12
`define GP_CODE_BASE      0
`define GP_PAST_BASE      64

// Samples per subframe
`define GP_SUBFR          40

//////////////////////////////////////////////////
// Constant ROM contents
//////////////////////////////////////////////////
// MA predictor taps, Q13
`define GP_PRED0          5571
`define GP_PRED1          4751
`define GP_PRED2          2785
`define GP_PRED3          1556
// Mean energy, placed in the high half by the predictor
`define GP_MEAN_ENER      30
`define GP_ROM_MEAN_ADDR  4

`endif

// ==== gain_pkg.sv ====
`include "gain_cfg.svh"

package gain_pkg;

	//////////////////////////////////////////////////
	// Opcodes and states
	//////////////////////////////////////////////////
	typedef enum logic [2:0]
	{
		OP_L_MAC,
		OP_L_MSU,
		OP_L_MULT,
		OP_MULT,
		OP_ADD,
		OP_SUB,
		OP_L_SHR
	} dsp_op_e;

	typedef enum logic [2:0]
	{
		IDLE,
		CLR,
		RD_CODE,
		ACC_CODE,
		NORM,
		RD_PRED,
		ACC_PRED,
		FINISH
	} gp_state_e;

	//////////////////////////////////////////////////
	// Bundles between blocks
	//////////////////////////////////////////////////
	// Operator call, c is the 32-bit accumulator or shift operand
	typedef struct packed
	{
		dsp_op_e     op;
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] c;
	} dsp_req_t;

	typedef struct packed
	{
		logic [31:0] res32;
		logic [15:0] res16;
		logic        overflow;
	} dsp_rsp_t;

	typedef struct packed
	{
		logic [`GP_ADDR_W-1:0] addr;
		logic [31:0]           data;
		logic                  en;
	} mem_wr_t;

	typedef struct packed
	{
		logic [15:0] gcode0;
		logic [15:0] exp_gcode0;
	} gain_result_t;

endpackage

// ==== basic_ops.sv ====
`timescale 1ns/1ps

module basic_ops
(
	input  gain_pkg::dsp_req_t i_req,
	output gain_pkg::dsp_rsp_t o_rsp
);
	import gain_pkg::*;

	logic signed [31:0] prod;
	logic               mult_sat;
	logic        [31:0] l_mult;
	logic        [32:0] mac_sum;
	logic        [32:0] msu_diff;
	logic        [16:0] sum16;
	logic        [16:0] diff16;
	logic         [4:0] shr_cnt;
	logic signed [31:0] shr_out;

	function automatic logic [31:0] sat32(input logic [32:0] v);
		if (v[32] == v[31])
			return v[31:0];
		return v[32] ? 32'h8000_0000 : 32'h7fff_ffff;
	endfunction

	function automatic logic [15:0] sat16(input logic [16:0] v);
		if (v[16] == v[15])
			return v[15:0];
		return v[16] ? 16'h8000 : 16'h7fff;
	endfunction

	assign prod = $signed(i_req.a) * $signed(i_req.b);

	// Only -32768 * -32768 overflows the doubled product
	assign mult_sat = (prod == 32'sh4000_0000);
	assign l_mult   = mult_sat ? 32'h7fff_ffff : {prod[30:0], 1'b0};

	assign mac_sum  = {i_req.c[31], i_req.c} + {l_mult[31], l_mult};
	assign msu_diff = {i_req.c[31], i_req.c} - {l_mult[31], l_mult};
	assign sum16    = {i_req.a[15], i_req.a} + {i_req.b[15], i_req.b};
	assign diff16   = {i_req.a[15], i_req.a} - {i_req.b[15], i_req.b};

	// Shift count clamps at 31, negative counts leave c alone
	assign shr_cnt = i_req.b[15] ? 5'd0 : (i_req.b > 16'd31) ? 5'd31 : i_req.b[4:0];
	assign shr_out = $signed(i_req.c) >>> shr_cnt;

	always_comb
	begin
		o_rsp = '0;
		case (i_req.op)
			OP_L_MAC:
			begin
				o_rsp.res32    = sat32(mac_sum);
				o_rsp.overflow = mult_sat | (mac_sum[32] ^ mac_sum[31]);
			end
			OP_L_MSU:
			begin
				o_rsp.res32    = sat32(msu_diff);
				o_rsp.overflow = mult_sat | (msu_diff[32] ^ msu_diff[31]);
			end
			OP_L_MULT:
			begin
				o_rsp.res32    = l_mult;
				o_rsp.overflow = mult_sat;
			end
			OP_MULT:
			begin
				o_rsp.res16    = mult_sat ? 16'h7fff : prod[30:15];
				o_rsp.overflow = mult_sat;
			end
			OP_ADD:
			begin
				o_rsp.res16    = sat16(sum16);
				o_rsp.overflow = sum16[16] ^ sum16[15];
			end
			OP_SUB:
			begin
				o_rsp.res16    = sat16(diff16);
				o_rsp.overflow = diff16[16] ^ diff16[15];
			end
			OP_L_SHR: o_rsp.res32 = shr_out;
			default: ;
		endcase
		// 16-bit results sign-extend, 32-bit ones also give extract_h
		if (i_req.op inside {OP_MULT, OP_ADD, OP_SUB})
			o_rsp.res32 = {{16{o_rsp.res16[15]}}, o_rsp.res16};
		else
			o_rsp.res16 = o_rsp.res32[31:16];
	end

endmodule

// ==== norm_shift.sv ====
`timescale 1ns/1ps

module norm_shift
(
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic        i_start,
	input  logic [31:0] i_value,
	output logic        o_done,
	output logic [15:0] o_norm,
	output logic [31:0] o_shifted
);

	logic busy;
	logic normalized;

	// Zero and all-ones stop at once
	assign normalized = (o_shifted[31] != o_shifted[30])
		|| (o_shifted == 32'h0000_0000)
		|| (o_shifted == 32'hffff_ffff);

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			busy   <= 1'b0;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_start)
				busy <= 1'b1;
			else if (busy && normalized)
			begin
				busy   <= 1'b0;
				o_done <= 1'b1;
			end
		end
	end

	// One bit position per cycle, norm_l and L_shl together
	always_ff @(posedge i_clock)
	begin
		if (i_start)
		begin
			o_shifted <= i_value;
			o_norm    <= '0;
		end
		else if (busy && !normalized)
		begin
			o_shifted <= {o_shifted[30:0], 1'b0};
			o_norm    <= o_norm + 16'd1;
		end
	end

endmodule

// ==== scratch_mem.sv ====
`timescale 1ns/1ps
`include "gain_cfg.svh"

module scratch_mem
(
	input  logic                  i_clock,
	input  logic                  i_test_sel,
	input  gain_pkg::mem_wr_t     i_wr,
	input  gain_pkg::mem_wr_t     i_test_wr,
	input  logic [`GP_ADDR_W-1:0] i_rd_addr,
	input  logic [`GP_ADDR_W-1:0] i_test_rd_addr,
	output logic [31:0]           o_rd_data
);
	import gain_pkg::*;

	localparam int DEPTH = 2 ** `GP_ADDR_W;

	mem_wr_t               wr_sel;
	logic [`GP_ADDR_W-1:0] rd_sel;
	logic [31:0]           mem [DEPTH];

	// Test port takes both sides while selected
	assign wr_sel = i_test_sel ? i_test_wr : i_wr;
	assign rd_sel = i_test_sel ? i_test_rd_addr : i_rd_addr;

	always_ff @(posedge i_clock)
	begin
		if (wr_sel.en)
			mem[wr_sel.addr] <= wr_sel.data;
	end

	// Registered read, one cycle latency
	always_ff @(posedge i_clock)
	begin
		o_rd_data <= mem[rd_sel];
	end

endmodule

// ==== const_rom.sv ====
`timescale 1ns/1ps
`include "gain_cfg.svh"

module const_rom
(
	input  logic                  i_clock,
	input  logic [`GP_ADDR_W-1:0] i_addr,
	output logic [31:0]           o_data
);

	localparam int AW = `GP_ADDR_W;

	// Predictor taps at 0 to 3, mean energy after them
	always_ff @(posedge i_clock)
	begin
		case (i_addr)
			AW'(0):                 o_data <= 32'(`GP_PRED0);
			AW'(1):                 o_data <= 32'(`GP_PRED1);
			AW'(2):                 o_data <= 32'(`GP_PRED2);
			AW'(3):                 o_data <= 32'(`GP_PRED3);
			AW'(`GP_ROM_MEAN_ADDR): o_data <= 32'(`GP_MEAN_ENER);
			default:                o_data <= '0;
		endcase
	end

endmodule

// ==== gain_predict.sv ====
`timescale 1ns/1ps
`include "gain_cfg.svh"

module gain_predict
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_start,
	output logic                   o_done,
	output gain_pkg::gain_result_t o_result,
	output logic [`GP_ADDR_W-1:0]  o_scr_rd_addr,
	input  logic [31:0]            i_scr_rd_data,
	output gain_pkg::mem_wr_t      o_scr_wr,
	output logic [`GP_ADDR_W-1:0]  o_rom_addr,
	input  logic [31:0]            i_rom_data,
	output gain_pkg::dsp_req_t     o_dsp_req,
	input  gain_pkg::dsp_rsp_t     i_dsp_rsp,
	output logic                   o_norm_start,
	output logic [31:0]            o_norm_value,
	input  logic                   i_norm_done,
	input  logic [15:0]            i_norm,
	input  logic [31:0]            i_norm_shifted
);
	import gain_pkg::*;

	localparam int ADDR_W    = `GP_ADDR_W;
	localparam int CNT_W     = $clog2(`GP_SUBFR);
	localparam int PRED_TAPS = 4;

	gp_state_e        state;
	logic [CNT_W-1:0] cnt;
	logic [31:0]      ener_acc;
	logic [31:0]      pred_acc;
	logic [15:0]      ener_half;
	logic [15:0]      norm_q;
	logic [15:0]      exp_q;

	assign o_norm_value = ener_acc;

	// Predictor never stores to scratch
	assign o_scr_wr.addr = o_scr_rd_addr;
	assign o_scr_wr.data = ener_acc;
	assign o_scr_wr.en   = 1'b0;

	//////////////////////////////////////////////////
	// Operator requests, one call per cycle
	//////////////////////////////////////////////////
	always_comb
	begin
		o_dsp_req = '0;
		case (state)
			ACC_CODE:
			begin
				o_dsp_req.a = i_scr_rd_data[15:0];
				o_dsp_req.b = i_scr_rd_data[15:0];
				o_dsp_req.c = ener_acc;
			end
			NORM:
			begin
				// Shift by 17 gives extract_h already halved
				o_dsp_req.op = OP_L_SHR;
				o_dsp_req.b  = 16'd17;
				o_dsp_req.c  = i_norm_shifted;
			end
			RD_PRED:
			begin
				o_dsp_req.op = OP_SUB;
				o_dsp_req.a  = 16'd14;
				o_dsp_req.b  = norm_q;
			end
			ACC_PRED:
			begin
				o_dsp_req.a = i_rom_data[15:0];
				o_dsp_req.b = i_scr_rd_data[15:0];
				o_dsp_req.c = pred_acc;
			end
			FINISH:
			begin
				o_dsp_req.op = OP_SUB;
				o_dsp_req.a  = pred_acc[31:16];
				o_dsp_req.b  = ener_half;
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			state        <= IDLE;
			cnt          <= '0;
			o_done       <= 1'b0;
			o_norm_start <= 1'b0;
		end
		else
		begin
			o_done       <= 1'b0;
			o_norm_start <= 1'b0;
			case (state)
				IDLE:
					if (i_start)
						state <= CLR;
				CLR:
					state <= RD_CODE;
				RD_CODE:
				begin
					cnt   <= '0;
					state <= ACC_CODE;
				end
				ACC_CODE:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`GP_SUBFR - 1))
					begin
						state        <= NORM;
						o_norm_start <= 1'b1;
					end
				end
				NORM:
					if (i_norm_done)
						state <= RD_PRED;
				RD_PRED:
				begin
					cnt   <= '0;
					state <= ACC_PRED;
				end
				ACC_PRED:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(PRED_TAPS))
						state <= FINISH;
				end
				FINISH:
				begin
					o_done <= 1'b1;
					state  <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Addresses run one ahead of the data being accumulated
	always_ff @(posedge i_clock)
	begin
		case (state)
			CLR:
			begin
				ener_acc      <= '0;
				o_scr_rd_addr <= ADDR_W'(`GP_CODE_BASE);
			end
			RD_CODE:
				o_scr_rd_addr <= o_scr_rd_addr + 1'b1;
			ACC_CODE:
			begin
				ener_acc      <= i_dsp_rsp.res32;
				o_scr_rd_addr <= o_scr_rd_addr + 1'b1;
			end
			NORM:
				if (i_norm_done)
				begin
					ener_half  <= i_dsp_rsp.res32[15:0];
					norm_q     <= i_norm;
					o_rom_addr <= ADDR_W'(`GP_ROM_MEAN_ADDR);
				end
			RD_PRED:
			begin
				exp_q         <= i_dsp_rsp.res16;
				o_rom_addr    <= '0;
				o_scr_rd_addr <= ADDR_W'(`GP_PAST_BASE);
			end
			ACC_PRED:
			begin
				o_rom_addr    <= o_rom_addr + 1'b1;
				o_scr_rd_addr <= o_scr_rd_addr + 1'b1;
				// First word back is the mean energy
				if (cnt == '0)
					pred_acc <= {i_rom_data[15:0], 16'h0000};
				else
					pred_acc <= i_dsp_rsp.res32;
			end
			FINISH:
			begin
				o_result.gcode0     <= i_dsp_rsp.res16;
				o_result.exp_gcode0 <= exp_q;
			end
			default: ;
		endcase
	end

endmodule

// ==== gain_predict_top.sv ====
`timescale 1ns/1ps
`include "gain_cfg.svh"

module gain_predict_top
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_start,
	output logic                   o_done,
	output gain_pkg::gain_result_t o_result,
	input  logic                   i_test_sel,
	input  gain_pkg::mem_wr_t      i_test_wr,
	input  logic [`GP_ADDR_W-1:0]  i_test_rd_addr,
	output logic [31:0]            o_test_rd_data
);
	import gain_pkg::*;

	logic [`GP_ADDR_W-1:0] scr_rd_addr;
	mem_wr_t               scr_wr;
	logic [`GP_ADDR_W-1:0] rom_addr;
	logic [31:0]           rom_data;
	dsp_req_t              dsp_req;
	dsp_rsp_t              dsp_rsp;
	logic                  norm_start;
	logic [31:0]           norm_value;
	logic                  norm_done;
	logic [15:0]           norm;
	logic [31:0]           norm_shifted;

	gain_predict u_predict
	(
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_start        (i_start),
		.o_done         (o_done),
		.o_result       (o_result),
		.o_scr_rd_addr  (scr_rd_addr),
		.i_scr_rd_data  (o_test_rd_data),
		.o_scr_wr       (scr_wr),
		.o_rom_addr     (rom_addr),
		.i_rom_data     (rom_data),
		.o_dsp_req      (dsp_req),
		.i_dsp_rsp      (dsp_rsp),
		.o_norm_start   (norm_start),
		.o_norm_value   (norm_value),
		.i_norm_done    (norm_done),
		.i_norm         (norm),
		.i_norm_shifted (norm_shifted)
	);

	basic_ops u_ops
	(
		.i_req (dsp_req),
		.o_rsp (dsp_rsp)
	);

	norm_shift u_norm
	(
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_start   (norm_start),
		.i_value   (norm_value),
		.o_done    (norm_done),
		.o_norm    (norm),
		.o_shifted (norm_shifted)
	);

	// Read data feeds the predictor and the test port alike
	scratch_mem u_scratch
	(
		.i_clock        (i_clock),
		.i_test_sel     (i_test_sel),
		.i_wr           (scr_wr),
		.i_test_wr      (i_test_wr),
		.i_rd_addr      (scr_rd_addr),
		.i_test_rd_addr (i_test_rd_addr),
		.o_rd_data      (o_test_rd_data)
	);

	const_rom u_rom
	(
		.i_clock (i_clock),
		.i_addr  (rom_addr),
		.o_data  (rom_data)
	);

endmodule

// ==== gain_predict_props.sv ====
`timescale 1ns/1ps

module gain_predict_props
(
	input logic              i_clock,
	input logic              i_rst_n,
	input logic              i_start,
	input logic              i_done,
	input logic              i_test_sel,
	input gain_pkg::mem_wr_t i_scr_wr
);

	logic seen_start;
	int   pulse_fails = 0;
	int   start_fails = 0;
	int   write_fails = 0;
	int   fail_count;

	assign fail_count = pulse_fails + start_fails + write_fails;

	// Armed by a start, used up by the o_done that ends the run
	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
			seen_start <= 1'b0;
		else if (i_start)
			seen_start <= 1'b1;
		else if (i_done)
			seen_start <= 1'b0;
	end

	done_is_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_done |=> !i_done)
		else
		begin
			$error("o_done stayed high for more than one cycle");
			pulse_fails++;
		end

	done_after_start: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_done |-> seen_start)
		else
		begin
			$error("o_done without any earlier start");
			start_fails++;
		end

	// Test port owns the memory while selected
	no_write_in_test: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(i_test_sel && i_scr_wr.en))
		else
		begin
			$error("predictor write while the test port is selected");
			write_fails++;
		end

endmodule

bind gain_predict_top gain_predict_props u_props
(
	.i_clock    (i_clock),
	.i_rst_n    (i_rst_n),
	.i_start    (i_start),
	.i_done     (o_done),
	.i_test_sel (i_test_sel),
	.i_scr_wr   (scr_wr)
);

// ==== gain_predict_tb.sv ====
`timescale 1ns/1ps
`include "gain_cfg.svh"

module gain_predict_tb;
	import gain_pkg::*;

	localparam int     CLK_PERIOD  = 8;
	localparam int     ADDR_W      = `GP_ADDR_W;
	localparam int     RUN_CYCLES  = `GP_SUBFR + 80;
	localparam int     LOAD_CYCLES = `GP_SUBFR + 8;
	localparam int     N_RUNS      = 26;
	localparam int     MEM_WORDS   = 32;
	localparam int     WATCHDOG_CYCLES = N_RUNS * (RUN_CYCLES + LOAD_CYCLES)
		+ 2 * RUN_CYCLES + 4 * MEM_WORDS + 500;
	localparam longint MAX32 = 64'sh7fff_ffff;
	localparam longint MIN32 = -64'sh8000_0000;
	localparam logic [15:0] PRED_TAPS [4] = '{16'(`GP_PRED0), 16'(`GP_PRED1),
		16'(`GP_PRED2), 16'(`GP_PRED3)};

	logic              clk;
	logic              rst_n;
	logic              start;
	logic              done;
	gain_result_t      result;
	logic              test_sel;
	mem_wr_t           test_wr;
	logic [ADDR_W-1:0] test_rd_addr;
	logic [31:0]       test_rd_data;

	logic [31:0] lfsr;
	logic [15:0] code_vec [`GP_SUBFR];
	logic [15:0] past_vec [4];
	int          checks;
	int          errors;
	int          test_checks;
	int          test_errors;

	gain_predict_top u_dut
	(
		.i_clock        (clk),
		.i_rst_n        (rst_n),
		.i_start        (start),
		.o_done         (done),
		.o_result       (result),
		.i_test_sel     (test_sel),
		.i_test_wr      (test_wr),
		.i_test_rd_addr (test_rd_addr),
		.o_test_rd_data (test_rd_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////
	// Stimulus source
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Random level, so the norm count varies
	function automatic logic [15:0] rand_sample();
		logic [15:0] s;
		logic [3:0]  sh;
		s  = 16'(rand_bits(16));
		sh = 4'(rand_bits(4));
		return 16'($signed(s) >>> sh);
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] l_mac(input logic [31:0] acc, input logic [15:0] a,
		input logic [15:0] b);
		longint p;
		longint s;
		p = longint'($signed(a)) * longint'($signed(b)) * 64'sd2;
		if (p > MAX32)
			p = MAX32;
		s = longint'($signed(acc)) + p;
		if (s > MAX32)
			s = MAX32;
		else if (s < MIN32)
			s = MIN32;
		return 32'(s);
	endfunction

	function automatic logic [15:0] sub_sat(input logic [15:0] a, input logic [15:0] b);
		int d;
		d = int'($signed(a)) - int'($signed(b));
		if (d > 32767)
			d = 32767;
		else if (d < -32768)
			d = -32768;
		return 16'(d);
	endfunction

	function automatic void norm_l(input logic [31:0] v, output logic [15:0] n,
		output logic [31:0] sh);
		sh = v;
		n  = '0;
		if (v == 32'h0000_0000 || v == 32'hffff_ffff)
			return;
		while (sh[31] == sh[30])
		begin
			sh = sh << 1;
			n  = n + 16'd1;
		end
	endfunction

	function automatic gain_result_t predict_model();
		logic [31:0]  ener_acc;
		logic [31:0]  pred_acc;
		logic [31:0]  shifted;
		logic [15:0]  nrm;
		logic [15:0]  ener;
		gain_result_t r;
		ener_acc = '0;
		for (int i = 0; i < `GP_SUBFR; i++)
			ener_acc = l_mac(ener_acc, code_vec[i], code_vec[i]);
		norm_l(ener_acc, nrm, shifted);
		ener     = shifted[31:16];
		pred_acc = {16'(`GP_MEAN_ENER), 16'h0000};
		for (int i = 0; i < 4; i++)
			pred_acc = l_mac(pred_acc, PRED_TAPS[i], past_vec[i]);
		r.gcode0     = sub_sat(pred_acc[31:16], 16'($signed(ener) >>> 1));
		r.exp_gcode0 = sub_sat(16'd14, nrm);
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////
	task automatic compare_result(input string name, input gain_result_t got,
		input gain_result_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error: %s gcode0 0x%h exp_gcode0 0x%h, expected 0x%h 0x%h",
				name, got.gcode0, got.exp_gcode0, exp.gcode0, exp.exp_gcode0);
		end
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error: %s 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic step_clock();
		@(posedge clk);
		#1;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
		test_wr.addr = addr;
		test_wr.data = data;
		test_wr.en   = 1'b1;
		step_clock();
	endtask

	task automatic load_case();
		test_sel = 1'b1;
		for (int i = 0; i < `GP_SUBFR; i++)
			write_word(ADDR_W'(`GP_CODE_BASE + i), {{16{code_vec[i][15]}}, code_vec[i]});
		for (int i = 0; i < 4; i++)
			write_word(ADDR_W'(`GP_PAST_BASE + i), {{16{past_vec[i][15]}}, past_vec[i]});
		test_wr.en = 1'b0;
		test_sel   = 1'b0;
	endtask

	task automatic randomize_case();
		for (int i = 0; i < `GP_SUBFR; i++)
			code_vec[i] = rand_sample();
		for (int i = 0; i < 4; i++)
			past_vec[i] = 16'(rand_bits(16));
	endtask

	task automatic pulse_start();
		start = 1'b1;
		step_clock();
		start = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!done && n < RUN_CYCLES)
		begin
			step_clock();
			n++;
		end
		if (!done)
		begin
			errors++;
			$display("No o_done within %0d cycles of the start", RUN_CYCLES);
		end
	endtask

	task automatic run_case();
		load_case();
		pulse_start();
		wait_done();
		compare_result("o_result", result, predict_model());
	endtask

	task automatic end_test(input int id, input string name);
		$display("Test %0d %s: %0d checks, %0d mismatches", id, name,
			checks - test_checks, errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	// Addresses step by an odd stride, so they never repeat
	task automatic memory_port_test();
		logic [ADDR_W-1:0] base;
		logic [31:0]       data_list [MEM_WORDS];
		base     = ADDR_W'(rand_bits(ADDR_W));
		test_sel = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			data_list[i] = rand_bits(32);
			write_word(ADDR_W'(int'(base) + i * 97), data_list[i]);
		end
		test_wr.en = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			test_rd_addr = ADDR_W'(int'(base) + i * 97);
			step_clock();
			compare_word("o_test_rd_data", test_rd_data, data_list[i]);
		end
		test_sel = 1'b0;
	endtask

	task automatic busy_start_test();
		int n_done;
		gain_result_t got;
		n_done = 0;
		got    = '0;
		randomize_case();
		load_case();
		pulse_start();
		repeat (5)
			step_clock();
		pulse_start();
		for (int c = 0; c < 2 * RUN_CYCLES; c++)
		begin
			if (done)
			begin
				n_done++;
				got = result;
			end
			step_clock();
		end
		checks++;
		if (n_done != 1)
		begin
			errors++;
			$display("Expected one o_done after an extra start, saw %0d", n_done);
		end
		compare_result("o_result", got, predict_model());
	endtask

	//////////////////////////////////////////////////
	// Watchdog and main sequence
	//////////////////////////////////////////////////
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		start        = 1'b0;
		test_sel     = 1'b0;
		test_wr      = '0;
		test_rd_addr = '0;
		lfsr         = 32'h27e9_e184;
		checks       = 0;
		errors       = 0;
		test_checks  = 0;
		test_errors  = 0;
		repeat (16)
			@(posedge clk);
		#1;
		rst_n = 1'b1;
		step_clock();

		memory_port_test();
		end_test(1, "memory test port");

		randomize_case();
		for (int i = 0; i < `GP_SUBFR; i++)
			code_vec[i] = 16'h0000;
		run_case();
		end_test(2, "zero code vector");

		for (int r = 0; r < 20; r++)
		begin
			randomize_case();
			run_case();
		end
		end_test(3, "random vectors");

		randomize_case();
		for (int i = 0; i < `GP_SUBFR; i++)
			code_vec[i] = 16'h8000;
		run_case();
		end_test(4, "full-scale samples");

		busy_start_test();
		// Same memory contents, each start right after o_done
		randomize_case();
		run_case();
		for (int r = 0; r < 2; r++)
		begin
			pulse_start();
			wait_done();
			compare_result("o_result", result, predict_model());
		end
		end_test(5, "start while busy, back-to-back");

		$display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
			checks, errors, u_dut.u_props.fail_count);
		if (errors == 0 && u_dut.u_props.fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
gain_pkg.sv
basic_ops.sv
norm_shift.sv
scratch_mem.sv
const_rom.sv
gain_predict.sv
gain_predict_top.sv
gain_predict_props.sv
gain_predict_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module gain_predict_tb \
	-o gain_predict_sim

out=$(./obj_dir/gain_predict_sim +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
